//--- ring_lsu.f
verilog/ring_lsu_pkg.sv
verilog/mem_latency_timer.sv
verilog/thread_req_regs.sv
verilog/ring_tx_fsm.sv
verilog/load_formatter.sv
verilog/ring_mem_node.sv
verilog/ring_lsu_top.sv
sim/tb_ring_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ring load/store unit testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --top-module tb_ring_lsu -Mdir "$OBJ_DIR" -f ring_lsu.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_ring_lsu" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0

//--- sim/tb_ring_lsu.sv
/* Testbench for the ring load/store unit. Issues random loads and stores from
   all four threads and checks stall, writeback and data against a RAM model. */

`timescale 1ns/100ps
`default_nettype none

module tb_ring_lsu;

  localparam int NT = ring_lsu_pkg::NUM_THREADS;
  localparam int TW = ring_lsu_pkg::THREAD_W;
  localparam int RW = ring_lsu_pkg::REG_SEL_W;
  localparam int NUM_ISSUES = 2000;
  localparam int CYCLE_LIMIT = NUM_ISSUES * 40;

  logic          CLK;
  logic          RST;
  logic [TW-1:0] slice;
  logic          req_cs;
  logic [31:0]   req_addr;
  logic          req_wr;
  logic [3:0]    req_mask;
  logic [31:0]   req_wdata;
  logic [RW-1:0] req_reg;
  wire  [NT-1:0] stall;
  wire           load_vld;
  wire  [TW-1:0] load_slice;
  wire  [RW-1:0] load_sel;
  wire  [31:0]   load_data;

  // Reference model of the RAM contents, the written bytes and the open requests
  integer        seed;
  logic [31:0]   model_mem [ring_lsu_pkg::MEM_DEPTH];
  logic [3:0]    model_known [ring_lsu_pkg::MEM_DEPTH];
  logic [NT-1:0] open_req;
  logic [NT-1:0] open_wr;
  int            age [NT];
  logic [31:0]   exp_data [NT];
  logic [31:0]   exp_kmask [NT];
  logic [RW-1:0] exp_reg [NT];
  int            issued;
  int            completed;
  int            cycles;

  // Inputs applied at the next rising edge
  logic [TW-1:0] nxt_slice;
  logic          nxt_cs;
  logic [31:0]   nxt_addr;
  logic          nxt_wr;
  logic [3:0]    nxt_mask;
  logic [31:0]   nxt_wdata;
  logic [RW-1:0] nxt_reg;

  ring_lsu_top ring_lsu_top_inst
  (
    .CLK        (CLK),
    .RST        (RST),
    .slice      (slice),
    .req_cs     (req_cs),
    .req_addr   (req_addr),
    .req_wr     (req_wr),
    .req_mask   (req_mask),
    .req_wdata  (req_wdata),
    .req_reg    (req_reg),
    .stall      (stall),
    .load_vld   (load_vld),
    .load_slice (load_slice),
    .load_sel   (load_sel),
    .load_data  (load_data)
  );

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Single bytes and aligned halfwords come back zero-extended
  function automatic logic [31:0] lane_select(input logic [31:0] word, input logic [3:0] mask);
    case (mask)
      4'b0001: lane_select = {24'd0, word[7:0]};
      4'b0010: lane_select = {24'd0, word[15:8]};
      4'b0100: lane_select = {24'd0, word[23:16]};
      4'b1000: lane_select = {24'd0, word[31:24]};
      4'b0011: lane_select = {16'd0, word[15:0]};
      4'b1100: lane_select = {16'd0, word[31:16]};
      default: lane_select = word;
    endcase
  endfunction

  function automatic logic [31:0] byte_expand(input logic [3:0] bits);
    byte_expand = {{8{bits[3]}}, {8{bits[2]}}, {8{bits[1]}}, {8{bits[0]}}};
  endfunction

  function automatic logic [3:0] pick_mask(input logic [2:0] sel);
    case (sel)
      3'd0: pick_mask = 4'b0001;
      3'd1: pick_mask = 4'b0010;
      3'd2: pick_mask = 4'b0100;
      3'd3: pick_mask = 4'b1000;
      3'd4: pick_mask = 4'b0011;
      3'd5: pick_mask = 4'b1100;
      default: pick_mask = 4'b1111;
    endcase
  endfunction

  // Picks the next slice and possibly a new request for its thread
  task automatic choose_request();
    logic [TW-1:0] thr;
    logic [31:0]   r;
    logic [31:0]   lo;
    logic [31:0]   up;
    logic [7:0]    widx;
    nxt_slice = nxt_slice + 1'b1;
    // The issue slice trails the thread slot by two
    thr = nxt_slice + 2'd2;
    nxt_cs = 1'b0;
    r = $random(seed);
    if (issued < NUM_ISSUES && !open_req[thr] && !stall[thr] && r[0])
    begin
      lo = $random(seed);
      up = $random(seed);
      // Each thread stays in its own quarter of the RAM
      widx = {thr, lo[5:0]};
      nxt_cs = 1'b1;
      nxt_wr = lo[8];
      nxt_mask = pick_mask(3'(lo[31:16] % 16'd7));
      nxt_addr = {up[11:0], up[21:12], thr, lo[5:0], 2'b00};
      nxt_wdata = $random(seed);
      nxt_reg = lo[12:9];
      open_req[thr] = 1'b1;
      open_wr[thr] = nxt_wr;
      age[thr] = 0;
      issued++;
      if (nxt_wr)
      begin
        for (int b = 0; b < 4; b++)
          if (nxt_mask[b])
            model_mem[widx][8*b +: 8] = nxt_wdata[8*b +: 8];
        model_known[widx] = model_known[widx] | nxt_mask;
      end
      else
      begin
        exp_data[thr] = lane_select(model_mem[widx], nxt_mask);
        exp_kmask[thr] = lane_select(byte_expand(model_known[widx]), nxt_mask);
        exp_reg[thr] = nxt_reg;
      end
    end
  endtask

  task automatic observe_outputs();
    logic [TW-1:0] t;
    if (load_vld)
    begin
      t = load_slice;
      check_value(32'(open_req[t] & ~open_wr[t]), 32'd1, "load_vld without an open load");
      check_value(32'(stall[t]), 32'd0, "stall still high at load writeback");
      check_value(32'(load_sel), 32'(exp_reg[t]), "load register number");
      // Bytes never written by the testbench are left out of the compare
      check_value(load_data & exp_kmask[t], exp_data[t] & exp_kmask[t], "load data");
      open_req[t] = 1'b0;
      completed++;
    end
    for (int k = 0; k < NT; k++)
      if (!open_req[k])
        check_value(32'(stall[k]), 32'd0, "stall high without an open request");
      else
      begin
        age[k]++;
        if (age[k] == 1)
          check_value(32'(stall[k]), 32'd0, "stall rose before the request was sampled");
        else if (age[k] == 2)
          check_value(32'(stall[k]), 32'd1, "stall did not rise after issue");
        else if (!stall[k])
        begin
          check_value(32'(open_wr[k]), 32'd1, "load stall fell without writeback");
          open_req[k] = 1'b0;
          completed++;
        end
      end
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d of %0d requests completed",
             cycles, completed, issued);
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial
  begin
    seed = 32'h808e;
    RST = 1'b1;
    slice = '0;
    req_cs = 1'b0;
    req_addr = '0;
    req_wr = 1'b0;
    req_mask = '0;
    req_wdata = '0;
    req_reg = '0;
    nxt_slice = '0;
    nxt_cs = 1'b0;
    nxt_addr = '0;
    nxt_wr = 1'b0;
    nxt_mask = '0;
    nxt_wdata = '0;
    nxt_reg = '0;
    open_req = '0;
    open_wr = '0;
    issued = 0;
    completed = 0;
    for (int i = 0; i < ring_lsu_pkg::MEM_DEPTH; i++)
    begin
      model_mem[i] = '0;
      model_known[i] = '0;
    end
    for (int k = 0; k < NT; k++)
    begin
      age[k] = 0;
      exp_data[k] = '0;
      exp_kmask[k] = '0;
      exp_reg[k] = '0;
    end

    repeat (7) @(posedge CLK);
    @(negedge CLK);
    check_value(32'(stall), 32'd0, "stall during reset");
    check_value(32'(load_vld), 32'd0, "load_vld during reset");
    @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    check_value(32'(stall), 32'd0, "stall after reset");
    check_value(32'(load_vld), 32'd0, "load_vld after reset");

    while (!(issued == NUM_ISSUES && completed == NUM_ISSUES))
    begin
      choose_request();
      @(posedge CLK);
      slice <= nxt_slice;
      req_cs <= nxt_cs;
      req_addr <= nxt_addr;
      req_wr <= nxt_wr;
      req_mask <= nxt_mask;
      req_wdata <= nxt_wdata;
      req_reg <= nxt_reg;
      @(negedge CLK);
      observe_outputs();
    end

    // Once every request has completed the ring stays quiet
    repeat (16)
    begin
      @(posedge CLK);
      req_cs <= 1'b0;
      @(negedge CLK);
      observe_outputs();
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/load_formatter.sv
/* Load writeback of the load/store node. Narrows the response data of an
   acked load to the requested lane and presents it with the register number. */

`timescale 1ns/100ps
`default_nettype none

module load_formatter
(
  input  wire                                                          CLK,
  input  wire                                                          RST,
  input  wire  ring_lsu_pkg::ring_word_u                               ring_in_q,
  input  wire  [ring_lsu_pkg::NUM_THREADS-1:0]                         ack,
  input  wire  [ring_lsu_pkg::NUM_THREADS*4-1:0]                       thr_mask,
  input  wire  [ring_lsu_pkg::NUM_THREADS-1:0]                         thr_wr,
  input  wire  [ring_lsu_pkg::NUM_THREADS*ring_lsu_pkg::REG_SEL_W-1:0] thr_reg,
  output logic                                                         load_vld,
  output logic [ring_lsu_pkg::THREAD_W-1:0]                            load_slice,
  output logic [ring_lsu_pkg::REG_SEL_W-1:0]                           load_sel,
  output logic [31:0]                                                  load_data
);

  localparam int RW = ring_lsu_pkg::REG_SEL_W;

  logic [ring_lsu_pkg::THREAD_W-1:0] thr;
  logic [3:0]                        lane_mask;
  logic [31:0]                       rdata;
  logic [31:0]                       lane_data;

  always_comb
  begin
    thr = ring_in_q.rsp.thread;
    lane_mask = thr_mask[thr*4 +: 4];
    rdata = ring_in_q.rsp.rdata;

    // Byte and halfword lanes come back zero-extended
    case (lane_mask)
      4'b0001: lane_data = {24'd0, rdata[7:0]};
      4'b0010: lane_data = {24'd0, rdata[15:8]};
      4'b0100: lane_data = {24'd0, rdata[23:16]};
      4'b1000: lane_data = {24'd0, rdata[31:24]};
      4'b0011: lane_data = {16'd0, rdata[15:0]};
      4'b1100: lane_data = {16'd0, rdata[31:16]};
      default: lane_data = rdata;
    endcase
  end

  // Write acks only release the stall
  always_ff @(posedge CLK or posedge RST)
    if (RST)
      load_vld <= 1'b0;
    else
      load_vld <= (|ack) && !thr_wr[thr];

  always_ff @(posedge CLK)
  begin
    load_slice <= thr;
    load_sel <= thr_reg[thr*RW +: RW];
    load_data <= lane_data;
  end

endmodule

`default_nettype wire

//--- verilog/mem_latency_timer.sv
/* Service latency timer of the memory node. A start loads the latency,
   busy holds while the count runs and done marks its last cycle. */

`timescale 1ns/100ps
`default_nettype none

module mem_latency_timer
(
  input  wire  CLK,
  input  wire  RST,
  input  wire  start,
  output logic busy,
  output logic done
);

  logic [ring_lsu_pkg::LAT_CNT_W-1:0] count;

  // A start in the done cycle reloads directly, so back-to-back requests
  // keep the node busy without a gap
  always_ff @(posedge CLK or posedge RST)
    if (RST)
      count <= '0;
    else if (start)
      count <= ring_lsu_pkg::LAT_LOAD;
    else if (busy)
      count <= count - 1'b1;

  assign busy = (count != '0);
  assign done = (count == 'd1);

endmodule

`default_nettype wire

//--- verilog/ring_lsu_pkg.sv
/* Shared definitions for the ring load/store unit: the 64-bit ring word,
   the load/store node ID, thread and memory sizes and the memory latency. */

`default_nettype none

package ring_lsu_pkg;

  // Thread organisation of the barrel core
  localparam int NUM_THREADS = 4;
  localparam int THREAD_W = 2;

  // Word address bits kept per request, taken from byte address bits 19:2
  localparam int ADDR_W = 18;

  // Writeback register number width
  localparam int REG_SEL_W = 4;

  // Ring ID of the load/store node, carried as source ID in every request
  localparam logic [5:0] LSU_NODE_ID = 6'h01;

  // Memory node RAM, indexed by the low address bits
  localparam int MEM_DEPTH = 256;
  localparam int MEM_AW = $clog2(MEM_DEPTH);

  // Cycles the memory node stays busy for each request it accepts
  localparam int MEM_LATENCY = 3;
  localparam int LAT_CNT_W = $clog2(MEM_LATENCY + 1);
  localparam logic [LAT_CNT_W-1:0] LAT_LOAD = LAT_CNT_W'(MEM_LATENCY);

  // One ring word, seen as a request by the memory node and as a
  // response by the load/store node. A request that returns to its
  // sender unchanged is a retry and is read through the request view
  typedef union packed {
    struct packed {
      logic                valid;
      logic                is_req;
      logic [5:0]          src_id;
      logic [THREAD_W-1:0] thread;
      logic [3:0]          mask;
      logic [ADDR_W-1:0]   addr;
      logic [31:0]         wdata;
    } req;
    struct packed {
      logic                valid;
      logic                is_req;
      logic [5:0]          src_id;
      logic [THREAD_W-1:0] thread;
      logic [21:0]         unused;
      logic [31:0]         rdata;
    } rsp;
  } ring_word_u;

endpackage

`default_nettype wire

//--- verilog/ring_lsu_top.sv
/* Load/store unit for a four-thread barrel core, closed into a two-node
   ring with one memory node. Stall bits hold each thread while it waits. */

`timescale 1ns/100ps
`default_nettype none

module ring_lsu_top
(
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire  [ring_lsu_pkg::THREAD_W-1:0]    slice,
  input  wire                                 req_cs,
  input  wire  [31:0]                         req_addr,
  input  wire                                 req_wr,
  input  wire  [3:0]                          req_mask,
  input  wire  [31:0]                         req_wdata,
  input  wire  [ring_lsu_pkg::REG_SEL_W-1:0]   req_reg,
  output wire  [ring_lsu_pkg::NUM_THREADS-1:0] stall,
  output wire                                 load_vld,
  output wire  [ring_lsu_pkg::THREAD_W-1:0]    load_slice,
  output wire  [ring_lsu_pkg::REG_SEL_W-1:0]   load_sel,
  output wire  [31:0]                         load_data
);

  localparam int NT = ring_lsu_pkg::NUM_THREADS;

  wire [NT-1:0]                          ack;
  wire [NT*ring_lsu_pkg::ADDR_W-1:0]     thr_addr;
  wire [NT*4-1:0]                        thr_mask;
  wire [NT-1:0]                          thr_wr;
  wire [NT*32-1:0]                       thr_wdata;
  wire [NT*ring_lsu_pkg::REG_SEL_W-1:0]  thr_reg;
  ring_lsu_pkg::ring_word_u              lsu_to_mem;
  ring_lsu_pkg::ring_word_u              mem_to_lsu;
  ring_lsu_pkg::ring_word_u              ring_in_q;

  // The pending bits are the stall outputs
  thread_req_regs thread_req_regs_inst
  (
    .CLK       (CLK),
    .RST       (RST),
    .slice     (slice),
    .req_cs    (req_cs),
    .req_addr  (req_addr),
    .req_wr    (req_wr),
    .req_mask  (req_mask),
    .req_wdata (req_wdata),
    .req_reg   (req_reg),
    .ack       (ack),
    .pending   (stall),
    .thr_addr  (thr_addr),
    .thr_mask  (thr_mask),
    .thr_wr    (thr_wr),
    .thr_wdata (thr_wdata),
    .thr_reg   (thr_reg)
  );

  ring_tx_fsm ring_tx_fsm_inst
  (
    .CLK       (CLK),
    .RST       (RST),
    .pending   (stall),
    .thr_addr  (thr_addr),
    .thr_mask  (thr_mask),
    .thr_wr    (thr_wr),
    .thr_wdata (thr_wdata),
    .ring_in   (mem_to_lsu),
    .ring_out  (lsu_to_mem),
    .ring_in_q (ring_in_q),
    .ack       (ack)
  );

  load_formatter load_formatter_inst
  (
    .CLK        (CLK),
    .RST        (RST),
    .ring_in_q  (ring_in_q),
    .ack        (ack),
    .thr_mask   (thr_mask),
    .thr_wr     (thr_wr),
    .thr_reg    (thr_reg),
    .load_vld   (load_vld),
    .load_slice (load_slice),
    .load_sel   (load_sel),
    .load_data  (load_data)
  );

  ring_mem_node ring_mem_node_inst
  (
    .CLK      (CLK),
    .RST      (RST),
    .ring_in  (lsu_to_mem),
    .ring_out (mem_to_lsu)
  );

endmodule

`default_nettype wire

//--- verilog/ring_mem_node.sv
/* Memory target node on the ring. Serves one request at a time from its RAM
   with a fixed latency and passes requests through unchanged while busy. */

`timescale 1ns/100ps
`default_nettype none

module ring_mem_node
(
  input  wire                      CLK,
  input  wire                      RST,
  input  wire  ring_lsu_pkg::ring_word_u ring_in,
  output ring_lsu_pkg::ring_word_u ring_out
);

  localparam int MAW = ring_lsu_pkg::MEM_AW;

  logic [31:0]                       mem [ring_lsu_pkg::MEM_DEPTH];
  logic [MAW-1:0]                    cap_addr;
  logic [5:0]                        cap_id;
  logic [ring_lsu_pkg::THREAD_W-1:0] cap_thread;
  logic                              req_in;
  logic                              start;
  logic                              busy;
  logic                              done;
  ring_lsu_pkg::ring_word_u          rsp_word;

  assign req_in = ring_in.req.valid && ring_in.req.is_req;

  // The node is free again in its done cycle, so a request arriving then
  // is captured while the previous response goes out
  assign start = req_in && (!busy || done);

  mem_latency_timer mem_latency_timer_inst
  (
    .CLK   (CLK),
    .RST   (RST),
    .start (start),
    .busy  (busy),
    .done  (done)
  );

  always_ff @(posedge CLK)
    if (start)
    begin
      cap_addr <= ring_in.req.addr[MAW-1:0];
      cap_id <= ring_in.req.src_id;
      cap_thread <= ring_in.req.thread;
    end

  // Writes land at capture time, so the response reads back the updated word
  always_ff @(posedge CLK)
    if (start)
      for (int b = 0; b < 4; b++)
        if (ring_in.req.mask[b])
          mem[ring_in.req.addr[MAW-1:0]][8*b +: 8] <= ring_in.req.wdata[8*b +: 8];

  always_comb
  begin
    rsp_word = '0;
    rsp_word.rsp.valid = 1'b1;
    rsp_word.rsp.is_req = 1'b0;
    rsp_word.rsp.src_id = cap_id;
    rsp_word.rsp.thread = cap_thread;
    rsp_word.rsp.rdata = mem[cap_addr];
  end

  // Words arriving while busy go back around to their sender as retries
  always_ff @(posedge CLK or posedge RST)
    if (RST)
      ring_out <= '0;
    else if (done)
      ring_out <= rsp_word;
    else if (ring_in.req.valid && busy)
      ring_out <= ring_in;
    else
      ring_out <= '0;

endmodule

`default_nettype wire

//--- verilog/ring_tx_fsm.sv
/* Ring interface of the load/store node. Sends each pending thread's request
   in its own rotating slot, registers the ring input and decodes ack/retry. */

`timescale 1ns/100ps
`default_nettype none

module ring_tx_fsm
(
  input  wire                                                       CLK,
  input  wire                                                       RST,
  input  wire  [ring_lsu_pkg::NUM_THREADS-1:0]                      pending,
  input  wire  [ring_lsu_pkg::NUM_THREADS*ring_lsu_pkg::ADDR_W-1:0] thr_addr,
  input  wire  [ring_lsu_pkg::NUM_THREADS*4-1:0]                    thr_mask,
  input  wire  [ring_lsu_pkg::NUM_THREADS-1:0]                      thr_wr,
  input  wire  [ring_lsu_pkg::NUM_THREADS*32-1:0]                   thr_wdata,
  input  wire  ring_lsu_pkg::ring_word_u                            ring_in,
  output ring_lsu_pkg::ring_word_u                                  ring_out,
  output ring_lsu_pkg::ring_word_u                                  ring_in_q,
  output logic [ring_lsu_pkg::NUM_THREADS-1:0]                      ack
);

  localparam int AW = ring_lsu_pkg::ADDR_W;

  logic [ring_lsu_pkg::THREAD_W-1:0]    slot;
  logic [ring_lsu_pkg::NUM_THREADS-1:0] sent;
  logic [ring_lsu_pkg::NUM_THREADS-1:0] send;
  logic [ring_lsu_pkg::NUM_THREADS-1:0] own_thr;
  logic [ring_lsu_pkg::NUM_THREADS-1:0] retry;
  ring_lsu_pkg::ring_word_u             req_word;

  always_ff @(posedge CLK or posedge RST)
    if (RST)
      ring_in_q <= '0;
    else
      ring_in_q <= ring_in;

  // Words carrying our own ID either answer a request or come back
  // unserved from a busy memory node
  always_comb
  begin
    own_thr = '0;
    if (ring_in_q.rsp.valid && (ring_in_q.rsp.src_id == ring_lsu_pkg::LSU_NODE_ID))
      own_thr[ring_in_q.rsp.thread] = 1'b1;
    ack = ring_in_q.rsp.is_req ? '0 : own_thr;
    retry = ring_in_q.req.is_req ? own_thr : '0;
  end

  // Request word for the thread owning the current slot
  always_comb
  begin
    send = '0;
    if (pending[slot] && !sent[slot])
      send[slot] = 1'b1;

    req_word = '0;
    req_word.req.valid = 1'b1;
    req_word.req.is_req = 1'b1;
    req_word.req.src_id = ring_lsu_pkg::LSU_NODE_ID;
    req_word.req.thread = slot;
    // Loads go out with no byte enabled so the memory node leaves the RAM alone
    req_word.req.mask = thr_wr[slot] ? thr_mask[slot*4 +: 4] : 4'd0;
    req_word.req.addr = thr_addr[slot*AW +: AW];
    req_word.req.wdata = thr_wdata[slot*32 +: 32];
  end

  // Slot state steps through threads 0..3 every cycle
  always_ff @(posedge CLK or posedge RST)
    if (RST)
    begin
      slot <= '0;
      ring_out <= '0;
    end
    else
    begin
      slot <= slot + 1'b1;
      ring_out <= (|send) ? req_word : '0;
    end

  // Sent stays set while the word is on the ring
  always_ff @(posedge CLK or posedge RST)
    if (RST)
      sent <= '0;
    else
      sent <= (sent | send) & ~(ack | retry);

endmodule

`default_nettype wire

//--- verilog/thread_req_regs.sv
/* Per-thread request state of the load/store node. Holds one open request
   per thread and its pending bit, which the top level drives out as stall. */

`timescale 1ns/100ps
`default_nettype none

module thread_req_regs
(
  input  wire                                                          CLK,
  input  wire                                                          RST,
  input  wire  [ring_lsu_pkg::THREAD_W-1:0]                            slice,
  input  wire                                                          req_cs,
  input  wire  [31:0]                                                  req_addr,
  input  wire                                                          req_wr,
  input  wire  [3:0]                                                   req_mask,
  input  wire  [31:0]                                                  req_wdata,
  input  wire  [ring_lsu_pkg::REG_SEL_W-1:0]                           req_reg,
  input  wire  [ring_lsu_pkg::NUM_THREADS-1:0]                         ack,
  output logic [ring_lsu_pkg::NUM_THREADS-1:0]                         pending,
  output logic [ring_lsu_pkg::NUM_THREADS*ring_lsu_pkg::ADDR_W-1:0]    thr_addr,
  output logic [ring_lsu_pkg::NUM_THREADS*4-1:0]                       thr_mask,
  output logic [ring_lsu_pkg::NUM_THREADS-1:0]                         thr_wr,
  output logic [ring_lsu_pkg::NUM_THREADS*32-1:0]                      thr_wdata,
  output logic [ring_lsu_pkg::NUM_THREADS*ring_lsu_pkg::REG_SEL_W-1:0] thr_reg
);

  localparam int AW = ring_lsu_pkg::ADDR_W;
  localparam int RW = ring_lsu_pkg::REG_SEL_W;

  logic [ring_lsu_pkg::THREAD_W-1:0]    issue_thr;
  logic [ring_lsu_pkg::NUM_THREADS-1:0] req_onehot;

  // The issue slice runs two stages behind the thread slot of the
  // pipeline, so slice 0 issues for thread 2, slice 1 for thread 3 and so on
  assign issue_thr = slice + 2'd2;

  always_comb
  begin
    req_onehot = '0;
    if (req_cs)
      req_onehot[issue_thr] = 1'b1;
  end

  // A thread only issues while its stall bit is low, so a new request
  // never meets an ack for the same thread
  always_ff @(posedge CLK or posedge RST)
    if (RST)
      pending <= '0;
    else
      pending <= (pending & ~ack) | req_onehot;

  // Request fields are held until the thread's ack
  always_ff @(posedge CLK)
    for (int k = 0; k < ring_lsu_pkg::NUM_THREADS; k++)
      if (req_onehot[k])
      begin
        thr_addr[k*AW +: AW] <= req_addr[AW+1:2];
        thr_mask[k*4 +: 4] <= req_mask;
        thr_wr[k] <= req_wr;
        thr_wdata[k*32 +: 32] <= req_wdata;
        thr_reg[k*RW +: RW] <= req_reg;
      end

endmodule

`default_nettype wire
